// File: verilog/minimig_pkg.sv
// shared address map and reset constants; the region tag is cpuaddress[23:19], 512 KB per tag
package minimig_pkg;

	// ------------------------------
	// bus widths
	// ------------------------------
	localparam int CPU_ADDR_W = 23;		// word address cpuaddress[23:1]
	localparam int RAM_ADDR_W = 19;		// sram word address ramaddress[19:1]
	localparam int DATA_W     = 16;		// 68000 data bus

	// ------------------------------
	// address map
	// ------------------------------
	// lowest bit looked at by the decoder
	localparam int REGION_SEL_LSB = 19;
	localparam int TAG_W          = CPU_ADDR_W - REGION_SEL_LSB + 1;	// 5 bit tag

	// tags in address bits 23:19
	localparam logic [TAG_W-1:0] CHIP_TOP  = 5'd1;		// chip ram is tags 0 and 1
	localparam logic [TAG_W-1:0] SLOW_BASE = 5'd24;		// 0xC00000
	localparam logic [TAG_W-1:0] KICK_BASE = 5'd31;		// 0xF80000

	// ------------------------------
	// reset timing
	// ------------------------------
	// release when this counter bit first sets, 2**RST_HOLD_BIT clocks
	localparam int RST_HOLD_BIT = 6;

	// ------------------------------
	// memory regions
	// ------------------------------
	typedef enum logic [2:0]
	{
		REGION_NONE    = 3'd0,	// unmapped, reads zero
		REGION_CHIP_LO = 3'd1,	// chip ram 0x000000..0x07FFFF
		REGION_CHIP_HI = 3'd2,	// chip ram 0x080000..0x0FFFFF
		REGION_SLOW    = 3'd3,	// slow ram 0xC00000..0xC7FFFF
		REGION_KICK    = 3'd4	// kickstart 0xF80000..0xFFFFFF
	} mem_region_t;

endpackage

// File: verilog/sys_reset.sv
// kbdrst is asynchronous and sampled once; exrst is synchronous; release comes 64 clocks late
`timescale 1ns/1ps

module sys_reset
(
	input  logic clk,		// bus clock
	input  logic exrst,		// external reset, active low
	input  logic kbdrst,	// keyboard reset request, active high
	output logic reset,		// global reset, active high
	output logic _cpureset	// 68000 reset pin
);

	logic req;												// registered reset request
	logic [minimig_pkg::RST_HOLD_BIT:0] hold_cnt;		// hold timer

	// ------------------------------
	// input register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!exrst)
			req <= 1'b1;
		else
			req <= kbdrst;	// keyboard request through one flop
	end

	// ------------------------------
	// hold timer
	// ------------------------------
	// cleared while requested, then runs up to the hold bit and parks there
	always_ff @(posedge clk)
	begin
		if (!exrst || req)
			hold_cnt <= '0;
		else if (!hold_cnt[minimig_pkg::RST_HOLD_BIT])
			hold_cnt <= hold_cnt + 1'b1;
	end

	// registered global reset
	always_ff @(posedge clk)
	begin
		if (!exrst)
			reset <= 1'b1;	// active from the first exrst cycle
		else
			reset <= ~hold_cnt[minimig_pkg::RST_HOLD_BIT];
	end

	assign _cpureset = ~reset;	// cpu held in reset with the system

	// ------------------------------
	// checks
	// ------------------------------
	// every request keeps the system in reset for the full hold time
	assert property (@(posedge clk) disable iff (!exrst)
		$fell(req) |=> reset [*64])
		else $error("reset released before hold time");

endmodule

// File: verilog/mem_decoder.sv
// combinational; only cpuaddress[23:19] is decoded, so each region repeats inside its 512 KB
`timescale 1ns/1ps

module mem_decoder
(
	input  logic [minimig_pkg::CPU_ADDR_W:1] cpuaddress,	// 68000 word address
	input  logic                             ovl,			// kickstart overlay
	output minimig_pkg::mem_region_t         region			// selected region
);

	logic [minimig_pkg::TAG_W-1:0] tag;	// 512 KB block number

	// ------------------------------
	// tag extraction
	// ------------------------------
	assign tag = cpuaddress[minimig_pkg::CPU_ADDR_W:minimig_pkg::REGION_SEL_LSB];

	// ------------------------------
	// region decode
	// ------------------------------
	always_comb
	begin
		region = minimig_pkg::REGION_NONE;	// anything not listed below
		if (tag == '0)
		begin
			// overlay puts the rom at address zero for the reset vector
			if (ovl)
				region = minimig_pkg::REGION_KICK;
			else
				region = minimig_pkg::REGION_CHIP_LO;
		end
		else if (tag == minimig_pkg::CHIP_TOP)
		begin
			region = minimig_pkg::REGION_CHIP_HI;	// second half of chip ram
		end
		else if (tag == minimig_pkg::SLOW_BASE)
		begin
			region = minimig_pkg::REGION_SLOW;		// trapdoor style slow ram
		end
		else if (tag == minimig_pkg::KICK_BASE)
		begin
			region = minimig_pkg::REGION_KICK;		// normal rom location
		end
	end

	// note: with ovl low, 0xF80000 is still kickstart, with ovl high
	// the rom is seen in both places and chip low is hidden

endmodule

// File: verilog/cpu_bridge.sv
// 68000 strobes are used directly, without input synchronizers; cycles end only when _as rises
`timescale 1ns/1ps

module cpu_bridge
(
	input  logic                           clk,			// bus clock
	input  logic                           reset,		// global reset
	input  logic                           _as,			// address strobe
	input  logic                           _uds,		// upper data strobe d15..d8
	input  logic                           _lds,		// lower data strobe d7..d0
	input  logic                           r_w,			// 1 read, 0 write
	input  logic [minimig_pkg::DATA_W-1:0] cpudata_in,	// write data from cpu
	input  logic [minimig_pkg::DATA_W-1:0] ram_rdata,	// read data from sram bridge
	output logic                           _dtack,		// data acknowledge
	output logic                           rd,			// bus read
	output logic                           hwr,			// bus high byte write
	output logic                           lwr,			// bus low byte write
	output logic [minimig_pkg::DATA_W-1:0] cpudata_out,	// read data to cpu
	output logic [minimig_pkg::DATA_W-1:0] ram_wdata	// write data to sram
);

	logic enable;	// cycle in progress and not yet acknowledged

	// ------------------------------
	// cycle decode
	// ------------------------------
	// open until dtack is given, so the strobes drop right after the ack edge
	assign enable = !reset && !_as && _dtack && (!_uds || !_lds);

	always_comb
	begin
		rd  = 1'b0;
		hwr = 1'b0;
		lwr = 1'b0;
		if (enable)
		begin
			if (r_w)
			begin
				rd = 1'b1;			// reads are always a full word
			end
			else
			begin
				hwr = !_uds;		// byte lanes follow the data strobes
				lwr = !_lds;
			end
		end
	end

	// ------------------------------
	// data acknowledge
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			_dtack <= 1'b1;
		else if (_as)
			_dtack <= 1'b1;		// end of cycle
		else if (enable)
			_dtack <= 1'b0;		// ack on the first enabled edge
	end

	// ------------------------------
	// data paths
	// ------------------------------
	// read latch holds while dtack is low
	always_ff @(posedge clk)
	begin
		if (enable)
			cpudata_out <= ram_rdata;	// zero on writes and unmapped reads
	end

	// write data only during a write strobe
	always_comb
	begin
		if (hwr || lwr)
			ram_wdata = cpudata_in;
		else
			ram_wdata = '0;
	end

	// ------------------------------
	// checks
	// ------------------------------
	assert property (@(posedge clk) !(rd && (hwr || lwr)))
		else $error("read and write strobes together");

	// data strobes only come inside an address strobe
	assert property (@(posedge clk) disable iff (reset)
		(!_uds || !_lds) |-> !_as)
		else $error("data strobe active without address strobe");

endmodule

// File: verilog/sram_bridge.sv
// combinational; kickstart is read only, and banks stay deselected while no strobe is active
`timescale 1ns/1ps

module sram_bridge
(
	input  minimig_pkg::mem_region_t       region,		// decoded region
	input  logic                           rd,			// bus read
	input  logic                           hwr,			// bus high write
	input  logic                           lwr,			// bus low write
	input  logic [minimig_pkg::DATA_W-1:0] ramdata,		// sram read data
	output logic [minimig_pkg::DATA_W-1:0] ram_rdata,	// read data to cpu bridge
	output logic                           _ramsel0,	// bank 0 select
	output logic                           _ramsel1,	// bank 1 select
	output logic                           address19,	// sram address line 19
	output logic                           _ub,			// upper byte
	output logic                           _lb,			// lower byte
	output logic                           _we,			// write enable
	output logic                           _oe			// output enable
);

	logic access;		// any strobe active
	logic en_chip_lo;	// 512 KB block enables
	logic en_chip_hi;
	logic en_slow;
	logic en_kick;
	logic enable;		// some block selected

	// ------------------------------
	// block enables
	// ------------------------------
	assign access     = rd || hwr || lwr;
	assign en_chip_lo = (region == minimig_pkg::REGION_CHIP_LO) && access;
	assign en_chip_hi = (region == minimig_pkg::REGION_CHIP_HI) && access;
	assign en_slow    = (region == minimig_pkg::REGION_SLOW) && access;
	assign en_kick    = (region == minimig_pkg::REGION_KICK) && rd;	// write protect
	assign enable     = en_chip_lo || en_chip_hi || en_slow || en_kick;

	// ------------------------------
	// bank mapping
	// ------------------------------
	// two 1 MB banks, each split in halves by line 19
	assign _ramsel0  = ~(en_chip_lo || en_chip_hi);	// chip ram
	assign _ramsel1  = ~(en_slow || en_kick);		// slow ram and rom
	assign address19 = en_chip_hi || en_kick;		// upper half

	// ------------------------------
	// control pins
	// ------------------------------
	assign _we = ~(enable && (hwr || lwr));
	assign _oe = ~(enable && rd);
	assign _ub = ~(enable && (rd || hwr));	// reads take both bytes
	assign _lb = ~(enable && (rd || lwr));

	// read data back to the bus, zero when not selected
	assign ram_rdata = (enable && rd) ? ramdata : '0;

	// ------------------------------
	// checks
	// ------------------------------
	// one region at a time from the decoder, so never both banks
	always_comb
	begin
		assert (_ramsel0 || _ramsel1)
			else $error("both sram banks selected");
	end

endmodule

// File: verilog/minimig_core.sv
// processor and sram side only; clock comes from outside, no dma, no bus sharing
`timescale 1ns/1ps

module minimig_core
(
	// system
	input  logic                               clk,			// bus clock
	input  logic                               exrst,		// external reset, active low
	input  logic                               kbdrst,		// keyboard reset
	input  logic                               ovl,			// kickstart overlay
	// 68000 pins
	input  logic [minimig_pkg::CPU_ADDR_W:1]   cpuaddress,	// address bus
	input  logic [minimig_pkg::DATA_W-1:0]     cpudata_in,	// data from cpu
	output logic [minimig_pkg::DATA_W-1:0]     cpudata_out,	// data to cpu
	input  logic                               _as,
	input  logic                               _uds,
	input  logic                               _lds,
	input  logic                               r_w,
	output logic                               _dtack,
	output logic                               _cpureset,
	// sram pins
	input  logic [minimig_pkg::DATA_W-1:0]     ramdata,		// sram read data
	output logic [minimig_pkg::DATA_W-1:0]     ram_wdata,	// sram write data
	output logic [minimig_pkg::RAM_ADDR_W:1]   ramaddress,	// sram word address
	output logic                               _ramsel0,
	output logic                               _ramsel1,
	output logic                               _ub,
	output logic                               _lb,
	output logic                               _we,
	output logic                               _oe
);

	logic                           reset;		// global reset
	minimig_pkg::mem_region_t       region;		// decoded region
	logic                           rd;			// bus strobes
	logic                           hwr;
	logic                           lwr;
	logic [minimig_pkg::DATA_W-1:0] ram_rdata;	// sram data to cpu bridge
	logic                           address19;	// bank half select

	// ------------------------------
	// reset and decode
	// ------------------------------
	sys_reset sys_reset_i
	(
		.clk       (clk),
		.exrst     (exrst),
		.kbdrst    (kbdrst),
		.reset     (reset),
		._cpureset (_cpureset)
	);

	mem_decoder mem_decoder_i
	(
		.cpuaddress (cpuaddress),
		.ovl        (ovl),
		.region     (region)
	);

	// ------------------------------
	// bridges
	// ------------------------------
	cpu_bridge cpu_bridge_i
	(
		.clk         (clk),
		.reset       (reset),
		._as         (_as),
		._uds        (_uds),
		._lds        (_lds),
		.r_w         (r_w),
		.cpudata_in  (cpudata_in),
		.ram_rdata   (ram_rdata),
		._dtack      (_dtack),
		.rd          (rd),
		.hwr         (hwr),
		.lwr         (lwr),
		.cpudata_out (cpudata_out),
		.ram_wdata   (ram_wdata)
	);

	sram_bridge sram_bridge_i
	(
		.region    (region),
		.rd        (rd),
		.hwr       (hwr),
		.lwr       (lwr),
		.ramdata   (ramdata),
		.ram_rdata (ram_rdata),
		._ramsel0  (_ramsel0),
		._ramsel1  (_ramsel1),
		.address19 (address19),
		._ub       (_ub),
		._lb       (_lb),
		._we       (_we),
		._oe       (_oe)
	);

	// low address lines straight from the cpu, line 19 from the bank mapping
	assign ramaddress = {address19, cpuaddress[minimig_pkg::RAM_ADDR_W-1:1]};

endmodule

// File: bench/cpu_tasks.svh
// included inside tb_minimig; drives the 68000 pins 5 ns after a rising edge and needs clk in scope

	// ------------------------------
	// idle bus
	// ------------------------------
	task automatic bus_idle();
		_as  = 1'b1;
		_uds = 1'b1;
		_lds = 1'b1;
		r_w  = 1'b1;	// idles as a read like the 68000
	endtask

	// runs one full 68000 cycle and returns the read latch, the sram pins seen
	// mid cycle and the edge counts for dtack fall and rise
	task automatic bus_cycle
	(
		input  logic [23:1] addr,
		input  logic        wr,			// 1 write, 0 read
		input  logic        ub,			// upper strobe active
		input  logic        lb,			// lower strobe active
		input  logic [15:0] wdata,
		output logic [15:0] rdata,
		output logic [4:0]  pins,		// {_ramsel0, _ramsel1, ramaddress[19], _we, _oe}
		output int          ack_edges,
		output int          rel_edges
	);
		int n;
		@(posedge clk);
		#5;
		cpuaddress = addr;
		cpudata_in = wdata;
		r_w        = ~wr;
		_uds       = ~ub;
		_lds       = ~lb;
		_as        = 1'b0;
		#1;
		pins = {_ramsel0, _ramsel1, ramaddress[19], _we, _oe};	// combinational path settled
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (_dtack && n < 8);	// bounded wait for the ack
		ack_edges = n;
		rdata     = cpudata_out;		// latch valid while dtack low
		#4;
		bus_idle();
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (!_dtack && n < 8);
		rel_edges = n;
	endtask

// File: bench/tb_minimig.sv
// single clock testbench; sram model is two 1 MB banks, kickstart half of bank 1 preloaded
`timescale 1ns/1ps

module tb_minimig;

	logic        clk;
	logic        exrst;
	logic        kbdrst;
	logic        ovl;
	logic [23:1] cpuaddress;
	logic [15:0] cpudata_in;
	logic [15:0] cpudata_out;
	logic        _as;
	logic        _uds;
	logic        _lds;
	logic        r_w;
	logic        _dtack;
	logic        _cpureset;
	logic [15:0] ramdata;
	logic [15:0] ram_wdata;
	logic [19:1] ramaddress;
	logic        _ramsel0;
	logic        _ramsel1;
	logic        _ub;
	logic        _lb;
	logic        _we;
	logic        _oe;

	logic [15:0] bank0 [0:524287];	// sram model bank 0 for chip ram
	logic [15:0] bank1 [0:524287];	// slow ram and rom
	logic [15:0] shadow [int];		// expected contents of writable ram
	int          cycle_cnt;

	minimig_core minimig_core_i
	(
		.clk (clk), .exrst (exrst), .kbdrst (kbdrst), .ovl (ovl),
		.cpuaddress (cpuaddress), .cpudata_in (cpudata_in), .cpudata_out (cpudata_out),
		._as (_as), ._uds (_uds), ._lds (_lds), .r_w (r_w),
		._dtack (_dtack), ._cpureset (_cpureset),
		.ramdata (ramdata), .ram_wdata (ram_wdata), .ramaddress (ramaddress),
		._ramsel0 (_ramsel0), ._ramsel1 (_ramsel1),
		._ub (_ub), ._lb (_lb), ._we (_we), ._oe (_oe)
	);

	`include "cpu_tasks.svh"

	// ------------------------------
	// clock and timeout
	// ------------------------------
	initial clk = 1'b0;
	always #50 clk = ~clk;	// 100 ns period

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > 20000)
		begin
			$display("timeout, the tests did not finish within 20000 cycles");
			$display("Errors found");
			$fatal(1);
		end
	end

	// ------------------------------
	// sram model
	// ------------------------------
	// rom pattern built from every address bit
	function automatic logic [15:0] rom_word(input logic [18:0] idx);
		return idx[15:0] ^ {idx[18:16], 13'h1a5};
	endfunction

	initial
	begin
		for (int i = 0; i < 524288; i++)
		begin
			bank0[i] = 16'h0000;
			bank1[i] = i[18] ? rom_word(19'(i)) : 16'h0000;	// upper half is kickstart
		end
	end

	assign ramdata = !_ramsel0 ? bank0[ramaddress] :
		(!_ramsel1 ? bank1[ramaddress] : 16'hdead);	// junk while no bank is selected

	always @(posedge clk)
	begin
		if (!_we && !_ramsel0)
		begin
			if (!_ub) bank0[ramaddress][15:8] <= ram_wdata[15:8];
			if (!_lb) bank0[ramaddress][7:0]  <= ram_wdata[7:0];
		end
		if (!_we && !_ramsel1)
		begin
			if (!_ub) bank1[ramaddress][15:8] <= ram_wdata[15:8];
			if (!_lb) bank1[ramaddress][7:0]  <= ram_wdata[7:0];
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------
	// {region, _ramsel0, _ramsel1, line 19, writable} for a read access
	function automatic logic [6:0] map_ref(input logic [23:1] addr, input logic ovl_in);
		logic [2:0] rg;
		logic       s0;
		logic       s1;
		logic       a19;
		logic       wok;
		rg  = minimig_pkg::REGION_NONE;
		s0  = 1'b1;
		s1  = 1'b1;
		a19 = 1'b0;
		wok = 1'b0;
		case (addr[23:19])
			5'd0:  rg = ovl_in ? minimig_pkg::REGION_KICK : minimig_pkg::REGION_CHIP_LO;
			5'd1:  rg = minimig_pkg::REGION_CHIP_HI;
			5'd24: rg = minimig_pkg::REGION_SLOW;
			5'd31: rg = minimig_pkg::REGION_KICK;
			default: rg = minimig_pkg::REGION_NONE;
		endcase
		case (rg)
			minimig_pkg::REGION_CHIP_LO:
			begin
				s0  = 1'b0;
				wok = 1'b1;
			end
			minimig_pkg::REGION_CHIP_HI:
			begin
				s0  = 1'b0;
				a19 = 1'b1;
				wok = 1'b1;
			end
			minimig_pkg::REGION_SLOW:
			begin
				s1  = 1'b0;
				wok = 1'b1;
			end
			minimig_pkg::REGION_KICK:
			begin
				s1  = 1'b0;
				a19 = 1'b1;
			end
			default:
			begin
				wok = 1'b0;	// unmapped
			end
		endcase
		return {rg, s0, s1, a19, wok};
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// one cycle with all of its checks and the shadow update
	task automatic run_checked(input logic [23:1] addr, input logic wr,
		input logic ub, input logic lb, input logic [15:0] wdata);
		logic [6:0]  ref_v;
		logic [4:0]  pins;
		logic [4:0]  exp_pins;
		logic [15:0] rdata;
		logic [15:0] exp_data;
		logic [15:0] old;
		int          key;
		int          ack_n;
		int          rel_n;
		ref_v = map_ref(addr, ovl);
		key   = int'({~ref_v[2], ref_v[1], addr[18:1]});	// bank, line 19, word
		if (!wr)
			exp_pins = {ref_v[3:1], 1'b1, (ref_v[6:4] == minimig_pkg::REGION_NONE)};	// _oe on mapped reads
		else if (ref_v[0])
			exp_pins = {ref_v[3:1], 2'b01};
		else
			exp_pins = 5'b11011;	// nothing selected on protected or unmapped writes
		bus_cycle(addr, wr, ub, lb, wdata, rdata, pins, ack_n, rel_n);
		check_val("sram pins {_ramsel0,_ramsel1,a19,_we,_oe}", 16'(pins), 16'(exp_pins));
		check_val("_dtack fall edges", 16'(ack_n), 16'd1);
		check_val("_dtack rise edges", 16'(rel_n), 16'd1);
		if (wr && ref_v[0])
		begin
			old = shadow.exists(key) ? shadow[key] : 16'h0000;
			if (ub) old[15:8] = wdata[15:8];
			if (lb) old[7:0]  = wdata[7:0];
			shadow[key] = old;
		end
		else if (!wr)
		begin
			if (ref_v[6:4] == minimig_pkg::REGION_NONE)
				exp_data = 16'h0000;	// unmapped reads zero
			else if (ref_v[6:4] == minimig_pkg::REGION_KICK)
				exp_data = rom_word({1'b1, addr[18:1]});
			else
				exp_data = shadow.exists(key) ? shadow[key] : 16'h0000;
			check_val("cpudata_out", rdata, exp_data);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		logic [31:0] rnd;
		logic [4:0]  tag;
		logic [23:1] addr;
		void'($urandom(65436));
		cycle_cnt  = 0;
		exrst      = 1'b0;
		kbdrst     = 1'b0;
		ovl        = 1'b0;
		cpuaddress = '0;
		cpudata_in = '0;
		bus_idle();

		// reset low during exrst and 66 clocks after it
		repeat (16)
		begin
			@(posedge clk);
			#1;
			check_val("_cpureset", 16'(_cpureset), 16'd0);
		end
		#4 exrst = 1'b1;
		for (int n = 1; n <= 66; n++)
		begin
			@(posedge clk);
			#1;
			check_val("_cpureset", 16'(_cpureset), (n < 66) ? 16'd0 : 16'd1);
		end

		// keyboard reset pulse
		@(posedge clk);
		#5 kbdrst = 1'b1;
		@(posedge clk);
		#5 kbdrst = 1'b0;
		for (int n = 1; n <= 66; n++)
		begin
			@(posedge clk);
			#1;
			check_val("_cpureset", 16'(_cpureset), (n >= 2 && n < 66) ? 16'd0 : 16'd1);
		end

		// read after write in chip and slow ram
		for (int i = 0; i < 200; i++)
		begin
			rnd  = $urandom;
			tag  = (rnd[31:30] == 2'd0) ? 5'd0 : ((rnd[31:30] == 2'd1) ? 5'd1 : 5'd24);
			addr = {tag, rnd[17:0]};
			rnd  = $urandom;
			run_checked(addr, 1'b1, 1'b1, 1'b1, rnd[15:0]);
			run_checked(addr, 1'b0, 1'b1, 1'b1, 16'h0000);
		end

		// byte lanes
		for (int i = 0; i < 20; i++)
		begin
			rnd  = $urandom;
			addr = {(rnd[31] ? 5'd24 : 5'd1), rnd[17:0]};
			run_checked(addr, 1'b1, 1'b1, 1'b1, rnd[15:0] ^ 16'h5a5a);
			run_checked(addr, 1'b1, rnd[30], ~rnd[30], rnd[31:16]);	// one strobe only
			run_checked(addr, 1'b0, 1'b1, 1'b1, 16'h0000);
		end

		// region mapping over the whole space
		for (int i = 0; i < 100; i++)
		begin
			rnd  = $urandom;
			addr = rnd[22:0];
			run_checked(addr, 1'b0, 1'b1, 1'b1, 16'h0000);
		end

		// kickstart write protect and overlay read at zero
		for (int i = 0; i < 20; i++)
		begin
			rnd  = $urandom;
			addr = {5'd31, rnd[17:0]};
			run_checked(addr, 1'b1, 1'b1, 1'b1, rnd[31:16]);
			run_checked(addr, 1'b0, 1'b1, 1'b1, 16'h0000);
		end
		#4 ovl = 1'b1;
		run_checked(23'h0, 1'b0, 1'b1, 1'b1, 16'h0000);
		ovl = 1'b0;

		$display("No errors");
		$finish;
	end

endmodule

// File: compile.f
verilog/minimig_pkg.sv
verilog/sys_reset.sv
verilog/mem_decoder.sv
verilog/cpu_bridge.sv
verilog/sram_bridge.sv
verilog/minimig_core.sv
+incdir+bench
bench/tb_minimig.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status is the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_minimig -o sim_minimig \
	&& ./obj_dir/sim_minimig \
	|| exit 1

exit 0
